/* sim.f */
+incdir+testbench
src/simCtrlPkg.sv
src/flagRegFile.sv
src/resetPulser.sv
src/coreSequencer.sv
src/backdoorRouter.sv
src/simCtrlTop.sv
testbench/simCtrlTb.sv

/* Makefile */
# Verilator build and run for the simulation control block

TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = simCtrlTb
FILELIST = sim.f
BUILD    = obj_dir
PASSMSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# Output goes to the terminal, grep decides the exit status
run: compile
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "$(PASSMSG)"

clean:
	rm -rf $(BUILD)

/* testbench/simCtrlChecks.svh */
// Testbench helpers for the simulation control block
// Random source, reference models and typed compare tasks

// Galois LFSR stepped once per random bit
function automatic logic [31:0] lfsrNext(logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
endfunction

function automatic logic [63:0] randBits(int n);
  logic [63:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsrState = lfsrNext(lfsrState);
    r = {r[62:0], lfsrState[0]};
  end
  return r;
endfunction

// ----------------------------------------
// Reference models
// ----------------------------------------
// Right-aligned ones over bits lsb..msb, capped at one value word
function automatic logic [FlagWidth-1:0] fieldOnes(int msb, int lsb);
  int w;
  w = msb - lsb + 1;
  if (w < 0) w = 0;
  if (w > int'(DataW)) w = int'(DataW);
  return (FlagWidth'(1) << w) - 1'b1;
endfunction

// Raw range write where bits lsb..msb take value bits 0 upward
function automatic logic [FlagWidth-1:0] writeRange(logic [FlagWidth-1:0] f, flagCmd_t c);
  logic [FlagWidth-1:0] m;
  logic [FlagWidth-1:0] v;
  m = fieldOnes(int'(c.msb), int'(c.lsb)) << c.lsb;
  v = FlagWidth'(c.value) << c.lsb;
  return (f & ~m) | (v & m);
endfunction

// Select query result and self-clearing command bits
function automatic logic [FlagWidth-1:0] clearCmdBits(logic [FlagWidth-1:0] f, logic sel);
  if (f[FlagGetBackdoorSel]) begin
    f[PatHi:PatLo] = '0;
    f[PatLo]       = sel;
  end
  for (int b = int'(FlagSetBackdoorSel); b <= int'(FlagSetProgramLoaded); b++) begin
    f[b] = 1'b0;
  end
  return f;
endfunction

// Right-aligned range read
function automatic logic [DataW-1:0] readRange(logic [FlagWidth-1:0] f, int msb, int lsb);
  return DataW'((f >> lsb) & fieldOnes(msb, lsb));
endfunction

// Byte address to memory word address
function automatic logic [MemAddrW-1:0] wordAddress(logic [BdAddrW-1:0] addr);
  return addr[BdAddrW-1:WordShift];
endfunction

// Byte i of a little-endian split
function automatic logic [ByteW-1:0] byteLane(logic [DataW-1:0] data, int i);
  return ByteW'(data >> (i * ByteW));
endfunction

// ----------------------------------------
// Compare tasks
// ----------------------------------------
task automatic stopRun(string why);
  $display("%s", why);
  $display("CHECKS FAILED");
  $fatal(1);
endtask

task automatic showMismatch(string name, logic [127:0] got, logic [127:0] exp);
  $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
  stopRun("Value mismatch");
endtask

task automatic checkFlagRsp(string name, flagRsp_t got, flagRsp_t exp);
  if (got !== exp) showMismatch(name, 128'(got), 128'(exp));
endtask

task automatic checkBdRsp(string name, bdRsp_t got, bdRsp_t exp);
  if (got !== exp) showMismatch(name, 128'(got), 128'(exp));
endtask

task automatic checkMemReq(string name, memReq_t got, memReq_t exp);
  if (got !== exp) showMismatch(name, 128'(got), 128'(exp));
endtask

task automatic checkSdReq(string name, sdReq_t got, sdReq_t exp);
  if (got !== exp) showMismatch(name, 128'(got), 128'(exp));
endtask

task automatic checkLevel(string name, logic got, logic exp);
  if (got !== exp) showMismatch(name, 128'(got), 128'(exp));
endtask

task automatic checkCount(string name, int got, int exp);
  if (got != exp) showMismatch(name, 128'(got), 128'(exp));
endtask

/* testbench/simCtrlTb.sv */
// Testbench for the simulation control block
// Drives flag commands, backdoor accesses and core handshakes, models
// the memories and cores, and checks the DUT against reference models
`timescale 1ns/1ps

module simCtrlTb
  import simCtrlPkg::*;
();

  localparam int CycleLimit = 2000;

  logic                clk;
  logic                arstN_i;
  flagCmd_t            flagCmd;
  flagRsp_t            flagRsp;
  logic                chipReset;
  logic                dmiReset;
  logic [NumCores-1:0] coreDone;
  logic [NumCores-1:0] coreReset;
  logic                seqBusy;
  bdReq_t              bdReq;
  logic                bdBusy;
  bdRsp_t              bdRsp;
  memReq_t             memReq;
  logic [DataW-1:0]    memRdata;
  sdReq_t              sdReq;
  logic [ByteW-1:0]    sdRdata;

  logic [31:0]          lfsrState = 32'd28;
  logic [FlagWidth-1:0] shadow;
  logic                 refSel;
  int                   cycleCnt;
  int                   bdRspCnt;
  int                   doneCnt [NumCores];
  bit [DataW-1:0]       memModel [bit [MemAddrW-1:0]];
  bit [ByteW-1:0]       sdMem [bit [BdAddrW-1:0]];
  logic [ByteW-1:0]     sdPend;
  memReq_t              memExpQ [$];
  sdReq_t               sdExpQ [$];
  bdRsp_t               bdExpQ [$];

  `include "simCtrlChecks.svh"

  simCtrlTop i_simCtrlTop (
    .clk         (clk),
    .arstN_i     (arstN_i),
    .flagCmd_i   (flagCmd),
    .flagRsp_o   (flagRsp),
    .chipReset_o (chipReset),
    .dmiReset_o  (dmiReset),
    .coreDone_i  (coreDone),
    .coreReset_o (coreReset),
    .seqBusy_o   (seqBusy),
    .bdReq_i     (bdReq),
    .bdBusy_o    (bdBusy),
    .bdRsp_o     (bdRsp),
    .memReq_o    (memReq),
    .memRdata_i  (memRdata),
    .sdReq_o     (sdReq),
    .sdRdata_i   (sdRdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run length guard
  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt >= CycleLimit) begin
      stopRun("Timeout: tests did not finish within the cycle limit");
    end
  end

  // ----------------------------------------
  // Memory and core models
  // ----------------------------------------
  // SD read bytes come back one cycle after their strobe
  always @(negedge clk) begin
    sdRdata = sdPend;
    if (sdReq.valid) begin
      if (sdReq.write) sdMem[sdReq.addr] = sdReq.wdata;
      sdPend = sdMem.exists(sdReq.addr) ? sdMem[sdReq.addr] : '0;
    end
    if (memReq.valid) begin
      if (memReq.write) memModel[memReq.addr] = memReq.wdata;
      memRdata = memModel.exists(memReq.addr) ? memModel[memReq.addr] : '0;
    end
  end

  // Core finishes a random number of cycles after its reset falls
  always @(negedge clk) begin
    for (int i = 0; i < int'(NumCores); i++) begin
      if (!arstN_i) begin
        coreDone[i] = 1'b0;
        doneCnt[i]  = 0;
      end else if (coreReset[i]) begin
        coreDone[i] = 1'b0;
        doneCnt[i]  = int'(randBits(3)) + 1;
      end else if (doneCnt[i] > 0) begin
        doneCnt[i]--;
      end else begin
        coreDone[i] = 1'b1;
      end
    end
  end

  // Request and response compare on pre-edge values
  always @(posedge clk) begin
    if (arstN_i && memReq.valid) begin
      if (memExpQ.size() == 0) begin
        stopRun("Main memory request issued with no access pending");
      end else begin
        checkMemReq("memReq_o", memReq, memExpQ.pop_front());
      end
    end
    if (arstN_i && sdReq.valid) begin
      if (sdExpQ.size() == 0) begin
        stopRun("SD flash request issued with no access pending");
      end else begin
        checkSdReq("sdReq_o", sdReq, sdExpQ.pop_front());
      end
    end
    if (arstN_i && bdRsp.valid) begin
      if (bdExpQ.size() == 0) begin
        stopRun("Backdoor response with no access pending");
      end else begin
        checkBdRsp("bdRsp_o", bdRsp, bdExpQ.pop_front());
        bdRspCnt++;
      end
    end
  end

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  task automatic flagWrite(int msb, int lsb, logic [DataW-1:0] value);
    logic [FlagWidth-1:0] raw;
    @(negedge clk);
    flagCmd = '{valid: 1'b1, write: 1'b1, msb: FlagIdxW'(msb), lsb: FlagIdxW'(lsb),
                value: value};
    raw     = writeRange(shadow, flagCmd);
    shadow  = clearCmdBits(raw, refSel);
    if (raw[FlagSetBackdoorSel]) refSel = raw[PatLo];
    @(negedge clk);
    flagCmd = '0;
  endtask

  task automatic flagRead(int msb, int lsb);
    flagRsp_t exp;
    @(negedge clk);
    flagCmd = '{valid: 1'b1, write: 1'b0, msb: FlagIdxW'(msb), lsb: FlagIdxW'(lsb),
                value: '0};
    exp     = '{valid: 1'b1, data: readRange(shadow, msb, lsb)};
    @(negedge clk);
    flagCmd = '0;
    checkFlagRsp("flagRsp_o", flagRsp, exp);
    // Valid lasts one cycle
    @(negedge clk);
    checkLevel("flagRsp_o.valid", flagRsp.valid, 1'b0);
  endtask

  task automatic bdAccess(logic wr, logic [BdAddrW-1:0] addr, logic [DataW-1:0] data,
                          logic [DataW-1:0] rdExp, logic sd, logic extra);
    int      target;
    memReq_t memExp;
    sdReq_t  sdExp;
    bdRsp_t  rspExp;
    target = bdRspCnt + 1;
    @(negedge clk);
    bdReq = '{valid: 1'b1, write: wr, addr: addr, data: data};
    if (sd) begin
      for (int i = 0; i < int'(SdBytes); i++) begin
        sdExp = '{valid: 1'b1, write: wr, addr: addr + BdAddrW'(i),
                  wdata: byteLane(data, i)};
        sdExpQ.push_back(sdExp);
      end
    end else begin
      memExp = '{valid: 1'b1, write: wr, addr: wordAddress(addr), wdata: data,
                 mask: '1};
      memExpQ.push_back(memExp);
    end
    rspExp = '{valid: 1'b1, data: wr ? DataW'(0) : rdExp};
    bdExpQ.push_back(rspExp);
    @(negedge clk);
    checkLevel("bdBusy_o", bdBusy, 1'b1);
    // Second request lands while busy and must be dropped
    if (extra) begin
      bdReq = '{valid: 1'b1, write: 1'b0, addr: addr ^ 32'h100, data: '0};
    end else begin
      bdReq = '0;
    end
    @(negedge clk);
    bdReq = '0;
    // Busy holds through the response cycle
    while (bdRspCnt < target) begin
      checkLevel("bdBusy_o", bdBusy, 1'b1);
      @(negedge clk);
    end
    checkLevel("bdBusy_o", bdBusy, 1'b0);
  endtask

  task automatic pulseLength(int bit_, logic isChip, int expLen);
    int n;
    flagWrite(bit_, bit_, 64'd1);
    n = 0;
    while (!(isChip ? chipReset : dmiReset)) @(negedge clk);
    while (isChip ? chipReset : dmiReset) begin
      n++;
      @(negedge clk);
    end
    checkCount(isChip ? "chipReset_o cycles" : "dmiReset_o cycles", n, expLen);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int                  lsbI;
    int                  msbI;
    int                  prev;
    logic [NumCores-1:0] mask;
    logic [BdAddrW-1:0]  addr;
    logic [DataW-1:0]    data;
    arstN_i  = 1'b0;
    flagCmd  = '0;
    bdReq    = '0;
    coreDone = '0;
    memRdata = '0;
    sdRdata  = '0;
    sdPend   = '0;
    shadow   = '0;
    refSel   = 1'b0;
    cycleCnt = 0;
    bdRspCnt = 0;
    repeat (16) @(negedge clk);
    arstN_i = 1'b1;
    @(negedge clk);

    // Random range writes kept clear of the command bits
    for (int k = 0; k < 24; k++) begin
      lsbI = int'(randBits(8));
      if (lsbI < 46) lsbI += 46;
      msbI = lsbI + int'(randBits(6));
      if (msbI > 255) msbI = 255;
      flagWrite(msbI, lsbI, randBits(64));
      flagRead(msbI, lsbI);
      lsbI = int'(randBits(8));
      msbI = lsbI + int'(randBits(6));
      if (msbI > 255) msbI = 255;
      flagRead(msbI, lsbI);
    end

    // Main memory write then read back
    addr = BdAddrW'(randBits(32));
    data = randBits(64);
    bdAccess(1'b1, addr, data, '0, 1'b0, 1'b1);
    bdAccess(1'b0, addr, '0, data, 1'b0, 1'b1);

    // Select SD flash and query it back
    flagWrite(FlagSetBackdoorSel, 0, (64'd1 << FlagSetBackdoorSel) | 64'd1);
    flagWrite(FlagGetBackdoorSel, FlagGetBackdoorSel, 64'd1);
    flagRead(PatHi, PatLo);
    flagRead(FlagSetProgramLoaded, FlagSetBackdoorSel);

    // SD flash path with eight little-endian bytes
    addr = BdAddrW'(randBits(32));
    data = randBits(64);
    bdAccess(1'b1, addr, data, '0, 1'b1, 1'b1);
    bdAccess(1'b0, addr, '0, data, 1'b1, 1'b0);

    pulseLength(FlagToggleChipReset, 1'b1, ChipResetCycles);
    pulseLength(FlagToggleDmiReset, 1'b0, DmiResetCycles);

    // Single-thread release
    mask = NumCores'(randBits(4));
    if (mask == '0) mask = 4'b1010;
    flagWrite(FlagForceSingleThread, 0, (64'd1 << FlagForceSingleThread) | 64'(mask));
    repeat (6) begin
      @(negedge clk);
      for (int i = 0; i < int'(NumCores); i++) checkLevel("coreReset_o", coreReset[i], 1'b1);
      checkLevel("seqBusy_o", seqBusy, 1'b1);
    end
    flagWrite(FlagSetProgramLoaded, 0, (64'd1 << FlagSetProgramLoaded) | 64'd1);
    prev = -1;
    for (int i = 0; i < int'(NumCores); i++) begin
      if (mask[i]) begin
        while (coreReset[i]) @(negedge clk);
        // Later cores still held and previous one finished
        for (int h = i + 1; h < int'(NumCores); h++) begin
          checkLevel("coreReset_o", coreReset[h], 1'b1);
        end
        if (prev >= 0) checkLevel("coreDone_i", coreDone[prev], 1'b1);
        prev = i;
      end
    end
    while (seqBusy) @(negedge clk);
    // Busy only drops once the last released core is done
    checkLevel("coreDone_i", coreDone[prev], 1'b1);
    for (int i = 0; i < int'(NumCores); i++) checkLevel("coreReset_o", coreReset[i], ~mask[i]);

    // Command bits never read back set
    flagRead(FlagSetProgramLoaded, FlagSetBackdoorSel);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* src/simCtrlTop.sv */
// Simulation control top level
// Flag register, reset pulses, core sequencing and backdoor routing
`timescale 1ns/1ps

module simCtrlTop
  import simCtrlPkg::*;
(
  input  logic                clk,
  input  logic                arstN_i,
  // Flag command port
  input  flagCmd_t            flagCmd_i,
  output flagRsp_t            flagRsp_o,
  // Reset outputs
  output logic                chipReset_o,
  output logic                dmiReset_o,
  // Core control
  input  logic [NumCores-1:0] coreDone_i,
  output logic [NumCores-1:0] coreReset_o,
  output logic                seqBusy_o,
  // Backdoor port
  input  bdReq_t              bdReq_i,
  output logic                bdBusy_o,
  output bdRsp_t              bdRsp_o,
  // Main memory
  output memReq_t             memReq_o,
  input  logic [DataW-1:0]    memRdata_i,
  // SD flash
  output sdReq_t              sdReq_o,
  input  logic [ByteW-1:0]    sdRdata_i
);

  ctrlPulse_t pulse;
  ctrlLevel_t level;

  // ----------------------------------------
  // Command decode
  // ----------------------------------------
  flagRegFile i_flagRegFile (
    .clk       (clk),
    .arstN_i   (arstN_i),
    .flagCmd_i (flagCmd_i),
    .flagRsp_o (flagRsp_o),
    .pulse_o   (pulse),
    .level_o   (level)
  );

  resetPulser i_resetPulser (
    .clk         (clk),
    .arstN_i     (arstN_i),
    .pulse_i     (pulse),
    .chipReset_o (chipReset_o),
    .dmiReset_o  (dmiReset_o)
  );

  coreSequencer i_coreSequencer (
    .clk         (clk),
    .arstN_i     (arstN_i),
    .pulse_i     (pulse),
    .level_i     (level),
    .coreDone_i  (coreDone_i),
    .coreReset_o (coreReset_o),
    .seqBusy_o   (seqBusy_o)
  );

  // ----------------------------------------
  // Backdoor path
  // ----------------------------------------
  backdoorRouter i_backdoorRouter (
    .clk        (clk),
    .arstN_i    (arstN_i),
    .level_i    (level),
    .bdReq_i    (bdReq_i),
    .bdBusy_o   (bdBusy_o),
    .bdRsp_o    (bdRsp_o),
    .memReq_o   (memReq_o),
    .memRdata_i (memRdata_i),
    .sdReq_o    (sdReq_o),
    .sdRdata_i  (sdRdata_i)
  );

endmodule

/* src/backdoorRouter.sv */
// Backdoor access router
// Sends 64-bit backdoor accesses to main memory as one word access or to
// the SD flash as eight little-endian byte accesses
`timescale 1ns/1ps

module backdoorRouter
  import simCtrlPkg::*;
(
  input  logic             clk,
  input  logic             arstN_i,
  input  ctrlLevel_t       level_i,
  input  bdReq_t           bdReq_i,
  output logic             bdBusy_o,
  output bdRsp_t           bdRsp_o,
  output memReq_t          memReq_o,
  input  logic [DataW-1:0] memRdata_i,
  output sdReq_t           sdReq_o,
  input  logic [ByteW-1:0] sdRdata_i
);

  // ----------------------------------------
  // State
  // ----------------------------------------
  typedef enum logic [2:0] {
    BdIdle,
    BdMemReq,
    BdMemRsp,
    BdSdXfer,
    BdSdRsp
  } bdState_e;

  bdState_e                     stateQ;
  logic [SdCntW-1:0]            cntQ;
  logic                         accept;
  bdReq_t                       reqQ;
  // Bytes 0..6, byte 7 is taken live in the response cycle
  logic [SdBytes-2:0][ByteW-1:0] sdBytesQ;
  logic [DataW-1:0]             rspData;

  assign accept = bdReq_i.valid & (stateQ == BdIdle);

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      stateQ <= BdIdle;
      cntQ   <= '0;
    end else begin
      case (stateQ)
        BdIdle: begin
          // Target chosen once per access
          if (accept) begin
            stateQ <= level_i.backdoorSel ? BdSdXfer : BdMemReq;
            cntQ   <= '0;
          end
        end
        BdMemReq: stateQ <= BdMemRsp;
        BdSdXfer: begin
          if (cntQ == SdCntW'(SdBytes - 1)) begin
            stateQ <= BdSdRsp;
          end else begin
            cntQ <= cntQ + 1'b1;
          end
        end
        default: stateQ <= BdIdle;
      endcase
    end
  end

  // Request copy and SD read bytes
  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ <= bdReq_i;
    end
    // Byte n-1 returns while byte n is requested
    if (stateQ == BdSdXfer && cntQ != '0) begin
      sdBytesQ[cntQ - 1'b1] <= sdRdata_i;
    end
  end

  // ----------------------------------------
  // Memory side requests
  // ----------------------------------------
  assign memReq_o.valid = (stateQ == BdMemReq);
  assign memReq_o.write = reqQ.write;
  assign memReq_o.addr  = MemAddrW'(reqQ.addr >> WordShift);
  assign memReq_o.wdata = reqQ.data;
  assign memReq_o.mask  = '1;

  // Little-endian byte walk
  assign sdReq_o.valid = (stateQ == BdSdXfer);
  assign sdReq_o.write = reqQ.write;
  assign sdReq_o.addr  = reqQ.addr + BdAddrW'(cntQ);
  assign sdReq_o.wdata = reqQ.data[cntQ*ByteW +: ByteW];

  // ----------------------------------------
  // Response
  // ----------------------------------------
  always_comb begin
    rspData = '0;
    // Writes answer with zero data
    if (!reqQ.write) begin
      if (stateQ == BdSdRsp) begin
        rspData = {sdRdata_i, sdBytesQ};
      end else begin
        rspData = memRdata_i;
      end
    end
  end

  assign bdRsp_o.valid = (stateQ == BdMemRsp) || (stateQ == BdSdRsp);
  assign bdRsp_o.data  = rspData;
  assign bdBusy_o      = (stateQ != BdIdle);

endmodule

/* src/coreSequencer.sv */
// Single-thread core sequencer
// Holds all cores in reset, waits for the program load, then releases
// the masked cores one at a time in index order
`timescale 1ns/1ps

module coreSequencer
  import simCtrlPkg::*;
(
  input  logic                clk,
  input  logic                arstN_i,
  input  ctrlPulse_t          pulse_i,
  input  ctrlLevel_t          level_i,
  input  logic [NumCores-1:0] coreDone_i,
  output logic [NumCores-1:0] coreReset_o,
  output logic                seqBusy_o
);

  // ----------------------------------------
  // State
  // ----------------------------------------
  typedef enum logic [1:0] {
    SeqIdle,
    SeqHold,
    SeqStep,
    SeqWait
  } seqState_e;

  seqState_e           stateQ;
  logic [CoreIdxW-1:0] idxQ;
  logic [NumCores-1:0] maskQ;
  logic [NumCores-1:0] resetQ;
  logic                lastCore;

  // Current core is the highest index
  assign lastCore = (idxQ == CoreIdxW'(NumCores - 1));

  // ----------------------------------------
  // Sequencing FSM
  // ----------------------------------------
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      stateQ <= SeqIdle;
      idxQ   <= '0;
      maskQ  <= '0;
      resetQ <= '0;
    end else if (pulse_i.singleThread) begin
      // Restart, every core back into reset
      stateQ <= SeqHold;
      idxQ   <= '0;
      maskQ  <= level_i.coreMask;
      resetQ <= '1;
    end else begin
      case (stateQ)
        SeqHold: begin
          // Wait for the program image
          if (level_i.programLoaded) begin
            stateQ <= SeqStep;
          end
        end
        SeqStep: begin
          if (maskQ[idxQ]) begin
            resetQ[idxQ] <= 1'b0;
            stateQ       <= SeqWait;
          end else if (lastCore) begin
            stateQ <= SeqIdle;
          end else begin
            // Unmasked core stays in reset
            idxQ <= idxQ + 1'b1;
          end
        end
        SeqWait: begin
          // Released core keeps running after done
          if (coreDone_i[idxQ]) begin
            if (lastCore) begin
              stateQ <= SeqIdle;
            end else begin
              idxQ   <= idxQ + 1'b1;
              stateQ <= SeqStep;
            end
          end
        end
        default: begin
          stateQ <= SeqIdle;
        end
      endcase
    end
  end

  assign coreReset_o = resetQ;
  assign seqBusy_o   = (stateQ != SeqIdle);

endmodule

/* src/resetPulser.sv */
// Reset pulse generator
// Stretches the chip and debug reset strobes into fixed-length pulses
`timescale 1ns/1ps

module resetPulser
  import simCtrlPkg::*;
(
  input  logic       clk,
  input  logic       arstN_i,
  input  ctrlPulse_t pulse_i,
  output logic       chipReset_o,
  output logic       dmiReset_o
);

  // ----------------------------------------
  // Channel setup
  // ----------------------------------------
  // Channel 0 is the chip reset, channel 1 the debug reset
  localparam int unsigned NumPulse = 2;
  localparam int unsigned MaxCycles =
    (ChipResetCycles > DmiResetCycles) ? ChipResetCycles : DmiResetCycles;
  localparam int unsigned CntW = $clog2(MaxCycles + 1);

  // Load values per channel
  localparam logic [NumPulse-1:0][CntW-1:0] PulseLen = {
    CntW'(DmiResetCycles),
    CntW'(ChipResetCycles)
  };

  logic [NumPulse-1:0]           strobe;
  logic [NumPulse-1:0][CntW-1:0] cntQ;
  logic [NumPulse-1:0]           active;

  assign strobe = {pulse_i.dmiReset, pulse_i.chipReset};

  // ----------------------------------------
  // Down-counters
  // ----------------------------------------
  for (genvar g = 0; g < NumPulse; g++) begin : genPulse

    always_ff @(posedge clk or negedge arstN_i) begin
      if (!arstN_i) begin
        cntQ[g] <= '0;
      end else if (active[g]) begin
        // Running, any new strobe is dropped
        cntQ[g] <= cntQ[g] - 1'b1;
      end else if (strobe[g]) begin
        cntQ[g] <= PulseLen[g];
      end
    end

    // High for exactly PulseLen cycles
    assign active[g] = (cntQ[g] != '0);

  end

  assign chipReset_o = active[0];
  assign dmiReset_o  = active[1];

endmodule

/* src/flagRegFile.sv */
// Flag register file
// 256-bit flag register with range write and read, plus decode of the
// self-clearing command bits into strobes and held control levels
`timescale 1ns/1ps

module flagRegFile
  import simCtrlPkg::*;
(
  input  logic       clk,
  input  logic       arstN_i,
  input  flagCmd_t   flagCmd_i,
  output flagRsp_t   flagRsp_o,
  output ctrlPulse_t pulse_o,
  output ctrlLevel_t level_o
);

  logic [FlagWidth-1:0] flagQ;
  logic [FlagWidth-1:0] flagWr;
  logic [FlagWidth-1:0] flagNext;
  logic [DataW-1:0]     rdData;
  logic [DataW-1:0]     rspDataQ;
  logic                 rspValidQ;
  logic                 cmdWrite;
  logic                 cmdRead;
  logic                 setSel;
  logic                 getSel;
  logic                 togChip;
  logic                 togDmi;
  logic                 forceSt;
  logic                 setLoaded;
  ctrlPulse_t           pulseQ;
  ctrlLevel_t           levelQ;

  assign cmdWrite = flagCmd_i.valid & flagCmd_i.write;
  assign cmdRead  = flagCmd_i.valid & ~flagCmd_i.write;

  // ----------------------------------------
  // Range write and read
  // ----------------------------------------
  always_comb begin
    int off;
    flagWr = flagQ;
    for (int i = 0; i < FlagWidth; i++) begin
      off = i - int'(flagCmd_i.lsb);
      // Bits lsb..msb take value bits 0 upward
      if (cmdWrite && off >= 0 && off < DataW && i <= int'(flagCmd_i.msb)) begin
        flagWr[i] = flagCmd_i.value[off];
      end
    end
  end

  always_comb begin
    int idx;
    rdData = '0;
    for (int j = 0; j < DataW; j++) begin
      idx = int'(flagCmd_i.lsb) + j;
      // Right-aligned, bits above msb stay zero
      if (idx <= int'(flagCmd_i.msb) && idx < FlagWidth) begin
        rdData[j] = flagQ[idx];
      end
    end
  end

  // ----------------------------------------
  // Command bit decode
  // ----------------------------------------
  assign setSel    = cmdWrite & flagWr[FlagSetBackdoorSel];
  assign getSel    = cmdWrite & flagWr[FlagGetBackdoorSel];
  assign togChip   = cmdWrite & flagWr[FlagToggleChipReset];
  assign togDmi    = cmdWrite & flagWr[FlagToggleDmiReset];
  assign forceSt   = cmdWrite & flagWr[FlagForceSingleThread];
  assign setLoaded = cmdWrite & flagWr[FlagSetProgramLoaded];

  always_comb begin
    flagNext = flagWr;
    // Select query answers in the pattern field, zero-extended
    if (getSel) begin
      flagNext[PatHi:PatLo] = '0;
      flagNext[PatLo]       = levelQ.backdoorSel;
    end
    // Command bits never get stored
    flagNext[FlagSetBackdoorSel]    = 1'b0;
    flagNext[FlagGetBackdoorSel]    = 1'b0;
    flagNext[FlagToggleChipReset]   = 1'b0;
    flagNext[FlagToggleDmiReset]    = 1'b0;
    flagNext[FlagForceSingleThread] = 1'b0;
    flagNext[FlagSetProgramLoaded]  = 1'b0;
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      flagQ     <= '0;
      pulseQ    <= '0;
      levelQ    <= '0;
      rspValidQ <= 1'b0;
    end else begin
      flagQ               <= flagNext;
      pulseQ.chipReset    <= togChip;
      pulseQ.dmiReset     <= togDmi;
      pulseQ.singleThread <= forceSt;
      rspValidQ           <= cmdRead;
      if (setSel) begin
        levelQ.backdoorSel <= flagWr[PatLo];
      end
      if (setLoaded) begin
        levelQ.programLoaded <= flagWr[PatLo];
      end
      // Mask comes from the low pattern bits
      if (forceSt) begin
        levelQ.coreMask <= flagWr[PatLo +: NumCores];
      end
    end
  end

  // Read data holder
  always_ff @(posedge clk) begin
    if (cmdRead) begin
      rspDataQ <= rdData;
    end
  end

  assign flagRsp_o = '{valid: rspValidQ, data: rspDataQ};
  assign pulse_o   = pulseQ;
  assign level_o   = levelQ;

endmodule

/* src/simCtrlPkg.sv */
// Simulation control shared definitions
// Flag register map, timing constants and the structs passed between blocks
package simCtrlPkg;

  // ----------------------------------------
  // Flag register geometry
  // ----------------------------------------
  localparam int unsigned FlagWidth = 256;
  localparam int unsigned FlagIdxW  = 8;
  localparam int unsigned DataW     = 64;
  // Pattern field carries command arguments and results
  localparam int unsigned PatLo     = 0;
  localparam int unsigned PatHi     = 31;

  // Core sequencing
  localparam int unsigned NumCores  = 4;
  localparam int unsigned CoreIdxW  = $clog2(NumCores);

  // Reset pulse lengths in clock cycles
  localparam int unsigned ChipResetCycles = 10;
  localparam int unsigned DmiResetCycles  = 10;

  // Backdoor geometry
  localparam int unsigned BdAddrW   = 32;
  localparam int unsigned ByteW     = 8;
  localparam int unsigned SdBytes   = 8;
  localparam int unsigned SdCntW    = $clog2(SdBytes);
  localparam int unsigned WordShift = 3;
  localparam int unsigned MemAddrW  = BdAddrW - WordShift;

  // ----------------------------------------
  // Self-clearing command bits
  // ----------------------------------------
  localparam int unsigned FlagSetBackdoorSel    = 40;
  localparam int unsigned FlagGetBackdoorSel    = 41;
  localparam int unsigned FlagToggleChipReset   = 42;
  localparam int unsigned FlagToggleDmiReset    = 43;
  localparam int unsigned FlagForceSingleThread = 44;
  localparam int unsigned FlagSetProgramLoaded  = 45;

  // ----------------------------------------
  // Structs
  // ----------------------------------------
  // Range command, value is right-aligned to lsb
  typedef struct packed {
    logic                valid;
    logic                write;
    logic [FlagIdxW-1:0] msb;
    logic [FlagIdxW-1:0] lsb;
    logic [DataW-1:0]    value;
  } flagCmd_t;

  typedef struct packed {
    logic             valid;
    logic [DataW-1:0] data;
  } flagRsp_t;

  // One-cycle strobes decoded from command bits
  typedef struct packed {
    logic chipReset;
    logic dmiReset;
    logic singleThread;
  } ctrlPulse_t;

  // Levels held until the next matching command
  typedef struct packed {
    logic                backdoorSel;
    logic                programLoaded;
    logic [NumCores-1:0] coreMask;
  } ctrlLevel_t;

  typedef struct packed {
    logic               valid;
    logic               write;
    logic [BdAddrW-1:0] addr;
    logic [DataW-1:0]   data;
  } bdReq_t;

  typedef struct packed {
    logic             valid;
    logic [DataW-1:0] data;
  } bdRsp_t;

  // Main memory word access
  typedef struct packed {
    logic                valid;
    logic                write;
    logic [MemAddrW-1:0] addr;
    logic [DataW-1:0]    wdata;
    logic [DataW/8-1:0]  mask;
  } memReq_t;

  // SD flash byte access
  typedef struct packed {
    logic               valid;
    logic               write;
    logic [BdAddrW-1:0] addr;
    logic [ByteW-1:0]   wdata;
  } sdReq_t;

endpackage
